// ==== Makefile ====
TOP := tb_div_unit
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/div_iter_core.sv ====
`include "div_settings.svh"

module div_iter_core (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               work_valid_i,
    input  div_pkg::div_work_t work_i,
    input  logic               fix_free_i,
    output logic               core_free_o,
    output logic               done_valid_o,
    output div_pkg::div_core_t done_o
);

    localparam int W = `DIV_WIDTH;

    div_pkg::div_state_e state;
    logic [2*W:0]        rq;
    logic [5:0]          cnt;
    logic [W-1:0]        divisor;
    logic                neg_quot;
    logic                neg_rem;
    logic                zero;
    logic [7:0]          tag;
    logic [W+1:0]        trial;
    logic                last_step;

    // Partial remainder with the next dividend bit, minus divisor; the top bit flags a borrow.
    assign trial     = {1'b0, rq[2*W:W]} - {2'b00, divisor};
    assign last_step = (cnt == 6'(W - 1));

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state <= div_pkg::CORE_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                div_pkg::CORE_IDLE: begin
                    if (work_valid_i) begin
                        cnt   <= '0;
                        state <= work_i.zero ? div_pkg::CORE_ZERO : div_pkg::CORE_RUN;
                    end
                end
                div_pkg::CORE_ZERO: begin
                    state <= div_pkg::CORE_DONE;
                end
                div_pkg::CORE_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= div_pkg::CORE_DONE;
                    end
                end
                div_pkg::CORE_DONE: begin
                    if (fix_free_i) begin
                        state <= div_pkg::CORE_IDLE;
                    end
                end
                default: begin
                    state <= div_pkg::CORE_IDLE;
                end
            endcase
        end
    end

    // Datapath registers follow the state but carry no reset.
    always_ff @(posedge clk) begin
        case (state)
            div_pkg::CORE_IDLE: begin
                if (work_valid_i) begin
                    rq       <= {{W{1'b0}}, work_i.dividend_mag, 1'b0};
                    divisor  <= work_i.divisor_mag;
                    neg_quot <= work_i.neg_quot;
                    neg_rem  <= work_i.neg_rem;
                    zero     <= work_i.zero;
                    tag      <= work_i.tag;
                end
            end
            div_pkg::CORE_ZERO: begin
                rq <= '0;
            end
            div_pkg::CORE_RUN: begin
                if (trial[W+1]) begin
                    rq <= {rq[2*W-1:0], 1'b0};
                end else begin
                    rq <= {trial[W-1:0], rq[W-1:0], 1'b1};
                end
            end
            default: begin
                rq <= rq;
            end
        endcase
    end

    assign core_free_o  = (state == div_pkg::CORE_IDLE);
    assign done_valid_o = (state == div_pkg::CORE_DONE);

    // Remainder sits above the spare bit, quotient in the low word.
    always_comb begin
        done_o.quot     = rq[W-1:0];
        done_o.rem      = rq[2*W:W+1];
        done_o.neg_quot = neg_quot;
        done_o.neg_rem  = neg_rem;
        done_o.zero     = zero;
        done_o.tag      = tag;
    end

endmodule

// ==== logic/div_operand_queue.sv ====
`include "div_settings.svh"

module div_operand_queue (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               req_valid_i,
    input  div_pkg::div_req_t  req_i,
    input  logic               core_free_i,
    output logic               req_credit_o,
    output logic               work_valid_o,
    output div_pkg::div_work_t work_o
);

    localparam int DEPTH = `DIV_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    div_pkg::div_req_t mem [DEPTH];
    div_pkg::div_req_t head;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;
    logic              dividend_neg;
    logic              divisor_neg;

    // The issuer only sends while it holds a credit, so a push always has room.
    assign push = req_valid_i && !flush_i;
    assign pop  = work_valid_o && core_free_i && !flush_i;

    assign work_valid_o = (count != '0);
    assign req_credit_o = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry converted to magnitudes.
    assign head         = mem[rd_ptr];
    assign dividend_neg = (head.op == div_pkg::DIV_OP_DIV) && head.dividend[`DIV_WIDTH-1];
    assign divisor_neg  = (head.op == div_pkg::DIV_OP_DIV) && head.divisor[`DIV_WIDTH-1];

    always_comb begin
        work_o.dividend_mag = dividend_neg ? (~head.dividend + 1'b1) : head.dividend;
        work_o.divisor_mag  = divisor_neg ? (~head.divisor + 1'b1) : head.divisor;
        work_o.neg_quot     = dividend_neg ^ divisor_neg;
        work_o.neg_rem      = dividend_neg;
        work_o.zero         = (head.divisor == '0);
        work_o.tag          = head.tag;
    end

endmodule

// ==== logic/div_pkg.sv ====
`include "div_settings.svh"

package div_pkg;

    typedef enum logic [0:0] {
        DIV_OP_DIVU = 1'b0,
        DIV_OP_DIV  = 1'b1
    } div_op_e;

    typedef enum logic [1:0] {
        CORE_IDLE = 2'd0,
        CORE_ZERO = 2'd1,
        CORE_RUN  = 2'd2,
        CORE_DONE = 2'd3
    } div_state_e;

    // Request as issued by the execute stage.
    typedef struct packed {
        div_op_e               op;
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
        logic [7:0]            tag;
    } div_req_t;

    // Magnitudes and sign decisions handed to the iterative core.
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend_mag;
        logic [`DIV_WIDTH-1:0] divisor_mag;
        logic                  neg_quot;
        logic                  neg_rem;
        logic                  zero;
        logic [7:0]            tag;
    } div_work_t;

    // Unsigned core result, signs still to be applied.
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] quot;
        logic [`DIV_WIDTH-1:0] rem;
        logic                  neg_quot;
        logic                  neg_rem;
        logic                  zero;
        logic [7:0]            tag;
    } div_core_t;

    // Response: remainder in hi, quotient in lo.
    typedef struct packed {
        logic [`DIV_WIDTH-1:0] hi;
        logic [`DIV_WIDTH-1:0] lo;
        logic                  div_by_zero;
        logic [7:0]            tag;
    } div_rsp_t;

endpackage

// ==== logic/div_settings.svh ====
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// Operand and result width.
`define DIV_WIDTH 32

// Operand queue entries, also the issuing side's starting credits.
`define DIV_QUEUE_DEPTH 2

// Responses the consumer can absorb before returning credits.
`define DIV_OUT_CREDITS 2

`endif

// ==== logic/div_sign_fix.sv ====
`include "div_settings.svh"

module div_sign_fix (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               done_valid_i,
    input  div_pkg::div_core_t done_i,
    input  logic               rsp_credit_i,
    output logic               fix_free_o,
    output logic               rsp_valid_o,
    output div_pkg::div_rsp_t  rsp_o
);

    localparam int CREDITS = `DIV_OUT_CREDITS;
    localparam int CRD_W   = $clog2(CREDITS + 1);

    logic              full;
    logic [CRD_W-1:0]  credits;
    logic              load;
    logic              send;
    div_pkg::div_rsp_t fixed;

    assign fix_free_o  = !full;
    assign load        = done_valid_i && !full && !flush_i;
    assign send        = full && (credits != '0) && !flush_i;
    assign rsp_valid_o = send;

    always_comb begin
        fixed.tag = done_i.tag;
        if (done_i.zero) begin
            fixed.hi          = '0;
            fixed.lo          = '0;
            fixed.div_by_zero = 1'b1;
        end else begin
            fixed.hi          = done_i.neg_rem ? (~done_i.rem + 1'b1) : done_i.rem;
            fixed.lo          = done_i.neg_quot ? (~done_i.quot + 1'b1) : done_i.quot;
            fixed.div_by_zero = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp_o <= fixed;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (send) begin
            full <= 1'b0;
        end
    end

    // Output credits survive a flush.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            credits <= CRD_W'(CREDITS);
        end else begin
            case ({send, rsp_credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== logic/div_unit.sv ====
module div_unit (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              flush_i,
    input  logic              req_valid_i,
    input  div_pkg::div_req_t req_i,
    input  logic              rsp_credit_i,
    output logic              req_credit_o,
    output logic              rsp_valid_o,
    output div_pkg::div_rsp_t rsp_o
);

    logic               work_valid;
    div_pkg::div_work_t work;
    logic               core_free;
    logic               done_valid;
    div_pkg::div_core_t done;
    logic               fix_free;

    // Magnitudes, zero check and input credits.
    div_operand_queue u_operand_queue (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .core_free_i  (core_free),
        .req_credit_o (req_credit_o),
        .work_valid_o (work_valid),
        .work_o       (work)
    );

    // One quotient bit per cycle.
    div_iter_core u_iter_core (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .work_valid_i (work_valid),
        .work_i       (work),
        .fix_free_i   (fix_free),
        .core_free_o  (core_free),
        .done_valid_o (done_valid),
        .done_o       (done)
    );

    // Signs, response register and output credits.
    div_sign_fix u_sign_fix (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .done_valid_i (done_valid),
        .done_i       (done),
        .rsp_credit_i (rsp_credit_i),
        .fix_free_o   (fix_free),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

// ==== tb.f ====
+incdir+logic
logic/div_pkg.sv
logic/div_operand_queue.sv
logic/div_iter_core.sv
logic/div_sign_fix.sv
logic/div_unit.sv
testbench/tb_div_unit.sv

// ==== testbench/div_testdata.txt ====
# REQ op dividend divisor expected_hi expected_lo expected_dbz, hex, op 0 is DIVU and 1 is DIV
# HOLD and RELEASE stop and resume credit returns, FLUSH discards, END_TEST closes a test
REQ 0 00000064 00000007 00000002 0000000e 0
REQ 0 00000005 00000009 00000005 00000000 0
REQ 0 ffffffff 00000001 00000000 ffffffff 0
REQ 0 80000000 00000003 00000002 2aaaaaaa 0
REQ 0 fffffff9 00000002 00000001 7ffffffc 0
END_TEST unsigned
REQ 1 00000007 00000002 00000001 00000003 0
REQ 1 fffffff9 00000002 ffffffff fffffffd 0
REQ 1 00000007 fffffffe 00000001 fffffffd 0
REQ 1 fffffff9 fffffffe ffffffff 00000003 0
REQ 1 80000000 ffffffff 00000000 80000000 0
REQ 1 ffffff9c 00000007 fffffffe fffffff2 0
REQ 1 80000000 00000002 00000000 c0000000 0
END_TEST signed
REQ 0 12345678 00000000 00000000 00000000 1
REQ 1 87654321 00000000 00000000 00000000 1
END_TEST div_by_zero
HOLD
REQ 0 000003e8 0000000a 00000000 00000064 0
REQ 0 00000011 00000003 00000002 00000005 0
REQ 1 ffffffec 00000003 fffffffe fffffffa 0
REQ 0 deadbeef 00010000 0000beef 0000dead 0
REQ 1 00000064 fffffff6 00000000 fffffff6 0
REQ 0 00000000 00000005 00000000 00000000 0
REQ 1 12345678 00000001 00000000 12345678 0
RELEASE
END_TEST backpressure
HOLD
REQ 0 00000009 00000002 00000001 00000004 0
REQ 0 00000063 0000000a 00000009 00000009 0
REQ 0 00000064 00000003 00000001 00000021 0
REQ 1 fffffffb 00000002 ffffffff fffffffe 0
REQ 0 00001000 00000010 00000000 00000100 0
FLUSH
RELEASE
REQ 0 0000002a 00000006 00000000 00000007 0
REQ 1 80000001 00000010 fffffff1 f8000001 0
END_TEST flush
REQ 0 00000001 00000001 00000000 00000001 0
REQ 1 ffffffff 00000001 00000000 ffffffff 0
REQ 0 7fffffff 00000002 00000001 3fffffff 0
REQ 1 7fffffff ffffffff 00000000 80000001 0
REQ 0 00000003 00000000 00000000 00000000 1
REQ 1 00000011 fffffffb 00000002 fffffffd 0
REQ 0 abcdef01 00000100 00000001 00abcdef 0
END_TEST streaming

// ==== testbench/tb_div_unit.sv ====
`include "div_settings.svh"

module tb_div_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string DATA_FILE = "testbench/div_testdata.txt";

    logic              clk;
    logic              rst_i;
    logic              flush_i;
    logic              req_valid_i;
    div_pkg::div_req_t req_i;
    logic              rsp_credit_i;
    logic              req_credit_o;
    logic              rsp_valid_o;
    div_pkg::div_rsp_t rsp_o;

    // Requests from the data file wait here until an issuing credit is free.
    div_pkg::div_req_t pend_q[$];
    div_pkg::div_rsp_t pend_exp_q[$];
    div_pkg::div_rsp_t exp_q[$];

    int         issue_credits = `DIV_QUEUE_DEPTH;
    int         owed = 0;
    int         credit_delay = 0;
    int         errors = 0;
    int         checks = 0;
    int         watchdog_cycles = 0;
    logic       hold = 1'b0;
    logic       flush_pending = 1'b0;
    logic [7:0] next_tag = 8'd0;

    div_unit u_div_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .rsp_credit_i (rsp_credit_i),
        .req_credit_o (req_credit_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

    always #2 clk = ~clk;

    task automatic drive_inputs();
        div_pkg::div_req_t req;
        div_pkg::div_rsp_t exp;
        req_valid_i  = 1'b0;
        flush_i      = 1'b0;
        rsp_credit_i = 1'b0;
        if (flush_pending) begin
            // Everything not yet delivered is gone, and the queue is empty again.
            flush_i       = 1'b1;
            flush_pending = 1'b0;
            exp_q.delete();
            issue_credits = `DIV_QUEUE_DEPTH;
        end else if (pend_q.size() != 0 && issue_credits > 0) begin
            req = pend_q.pop_front();
            exp = pend_exp_q.pop_front();
            req.tag = next_tag;
            exp.tag = next_tag;
            next_tag = next_tag + 8'd1;
            req_i = req;
            req_valid_i = 1'b1;
            issue_credits--;
            exp_q.push_back(exp);
            if (exp_q.size() > `DIV_QUEUE_DEPTH + 2) begin
                $display("Unit accepted more requests than its queue, core and output can hold");
                errors++;
            end
        end
        if (!hold && owed > 0) begin
            if (credit_delay > 0) begin
                credit_delay--;
            end else begin
                rsp_credit_i = 1'b1;
                owed--;
                credit_delay = $urandom % 4;
            end
        end
    endtask

    task automatic sample_outputs();
        div_pkg::div_rsp_t exp;
        if (req_credit_o) begin
            if (issue_credits >= `DIV_QUEUE_DEPTH) begin
                $display("Unit returned an input credit with no request outstanding");
                errors++;
            end
            issue_credits++;
        end
        if (rsp_valid_o) begin
            owed++;
            if (owed > `DIV_OUT_CREDITS) begin
                $display("Unit sent a response without an output credit (%0d outstanding)", owed);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Unexpected response with tag %h", rsp_o.tag);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                checks++;
                if (rsp_o.tag !== exp.tag) begin
                    $display("ERROR tag: expected %h, got %h", exp.tag, rsp_o.tag);
                    errors++;
                end
                if (rsp_o.hi !== exp.hi) begin
                    $display("ERROR hi: expected %h, got %h (tag %h)", exp.hi, rsp_o.hi, exp.tag);
                    errors++;
                end
                if (rsp_o.lo !== exp.lo) begin
                    $display("ERROR lo: expected %h, got %h (tag %h)", exp.lo, rsp_o.lo, exp.tag);
                    errors++;
                end
                if (rsp_o.div_by_zero !== exp.div_by_zero) begin
                    $display("ERROR div_by_zero: expected %h, got %h (tag %h)",
                             exp.div_by_zero, rsp_o.div_by_zero, exp.tag);
                    errors++;
                end
            end
        end
    endtask

    // Drive on the falling edge, then sample once the outputs have settled.
    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        #1;
        sample_outputs();
    endtask

    initial begin
        int                    fd;
        int                    nreq;
        int                    test_errors;
        int                    test_checks;
        int                    tests_ok;
        int                    tests_bad;
        string                 line;
        string                 cmd;
        string                 name;
        logic [3:0]            op_v;
        logic [3:0]            dbz_v;
        logic [`DIV_WIDTH-1:0] a_v;
        logic [`DIV_WIDTH-1:0] b_v;
        logic [`DIV_WIDTH-1:0] hi_v;
        logic [`DIV_WIDTH-1:0] lo_v;
        div_pkg::div_req_t     req;
        div_pkg::div_rsp_t     exp;

        void'($urandom(32'hc9b4_9aa1));
        clk          = 1'b0;
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        rsp_credit_i = 1'b0;
        tests_ok     = 0;
        tests_bad    = 0;

        nreq = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", DATA_FILE);
            errors++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s", cmd) == 1 && cmd == "REQ") begin
                nreq++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
            fd = $fopen(DATA_FILE, "r");
        end
        watchdog_cycles = nreq * 80 + 2000;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        test_errors = errors;
        test_checks = checks;

        while (fd != 0 && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%s", cmd) != 1 || cmd == "#") begin
                continue;
            end
            if (cmd == "REQ") begin
                void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, op_v, a_v, b_v,
                              hi_v, lo_v, dbz_v));
                req.op = op_v[0] ? div_pkg::DIV_OP_DIV : div_pkg::DIV_OP_DIVU;
                req.dividend = a_v;
                req.divisor = b_v;
                req.tag = '0;
                exp.hi = hi_v;
                exp.lo = lo_v;
                exp.div_by_zero = dbz_v[0];
                exp.tag = '0;
                pend_q.push_back(req);
                pend_exp_q.push_back(exp);
            end else if (cmd == "HOLD") begin
                hold = 1'b1;
            end else if (cmd == "RELEASE") begin
                // Let the unit fill up and stall before credits flow again.
                while (!(pend_q.size() == 0 || (issue_credits == 0 &&
                         owed == `DIV_OUT_CREDITS && exp_q.size() == `DIV_QUEUE_DEPTH + 2))) begin
                    run_cycle();
                end
                hold = 1'b0;
            end else if (cmd == "FLUSH") begin
                while (!(pend_q.size() == 0 && (exp_q.size() == 0 ||
                         (hold && owed == `DIV_OUT_CREDITS)))) begin
                    run_cycle();
                end
                flush_pending = 1'b1;
                run_cycle();
            end else if (cmd == "END_TEST") begin
                void'($sscanf(line, "%s %s", cmd, name));
                while (pend_q.size() != 0 || exp_q.size() != 0 || (owed != 0 && !hold)) begin
                    run_cycle();
                end
                if (issue_credits != `DIV_QUEUE_DEPTH) begin
                    $display("ERROR issue_credits: expected %h, got %h",
                             `DIV_QUEUE_DEPTH, issue_credits);
                    errors++;
                end
                $display("test %0s: %0d responses checked, %0d errors", name,
                         checks - test_checks, errors - test_errors);
                if (errors == test_errors) begin
                    tests_ok++;
                end else begin
                    tests_bad++;
                end
                test_errors = errors;
                test_checks = checks;
            end else begin
                $display("Unknown command in the stimulus file: %0s", cmd);
                errors++;
            end
        end

        // Stray responses after the last test still count.
        repeat (50) run_cycle();
        $display("%0d tests ok, %0d tests with errors, %0d errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run did not finish within %0d cycles, the unit appears to be stuck",
                 watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule
